/* Makefile */
VERILATOR ?= verilator
TOP ?= fb_write_tb
OBJ_DIR ?= obj_dir
FLIST ?= flist.f
VFLAGS ?= --binary --timing --timescale 1ns/1ps
PASS_MSG ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* axil_chunk_writer.sv */
`timescale 1ns/1ps

module axil_chunk_writer #(
  parameter fb_pkg::axil_addr_t FB_BASE = 32'h0000_0000
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  fb_pkg::chunk_t      chunk,
  input  logic                chunk_valid,
  output logic                chunk_ready,
  output fb_pkg::axil_addr_t  awaddr,
  output logic                awvalid,
  input  logic                awready,
  output fb_pkg::chunk_data_t wdata,
  output fb_pkg::strobe_t     wstrb,
  output logic                wvalid,
  input  logic                wready,
  input  logic [1:0]          bresp,
  input  logic                bvalid,
  output logic                bready,
  output logic [15:0]         err_count
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_RESP
  } state_t;

  localparam int RESP_ERR = 1;  // bresp bit, set for SLVERR and DECERR

  state_t state;
  logic aw_done;
  logic w_done;
  logic take_chunk;

  always_comb begin
    chunk_ready = (state == ST_IDLE);
    take_chunk = chunk_valid && chunk_ready;
    aw_done = !awvalid || awready;  // already accepted or accepted now
    w_done = !wvalid || wready;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ST_IDLE;
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      bready <= 1'b0;
      err_count <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (take_chunk) begin
            awvalid <= 1'b1;
            wvalid <= 1'b1;
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (awready) awvalid <= 1'b0;
          if (wready) wvalid <= 1'b0;
          if (aw_done && w_done) begin
            bready <= 1'b1;
            state <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (bvalid) begin
            bready <= 1'b0;
            if (bresp[RESP_ERR]) err_count <= err_count + 16'd1;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // byte address of the chunk inside the frame
  always_ff @(posedge clk_in) begin
    if (take_chunk) begin
      awaddr <= FB_BASE + fb_pkg::axil_addr_t'(chunk.addr) * fb_pkg::axil_addr_t'(fb_pkg::CHUNK_BYTES);
      wdata <= chunk.data;
      wstrb <= chunk.strb;
    end
  end

endmodule

/* chunk_fifo.sv */
`timescale 1ns/1ps

module chunk_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic           clk_in,
  input  logic           rst_in,
  input  fb_pkg::chunk_t in_chunk,
  input  logic           in_valid,
  output logic           in_ready,
  output fb_pkg::chunk_t out_chunk,
  output logic           out_valid,
  input  logic           out_ready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

  fb_pkg::chunk_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] count;
  logic do_wr;
  logic do_rd;

  always_comb begin
    in_ready = (count != FULL_COUNT);
    out_valid = (count != '0);
    out_chunk = mem[rd_ptr];
    do_wr = in_valid && in_ready;
    do_rd = out_valid && out_ready;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (do_wr) mem[wr_ptr] <= in_chunk;
  end

endmodule

/* fb_axil_mem_model.sv */
`timescale 1ns/1ps

module fb_axil_mem_model #(
  parameter fb_pkg::axil_addr_t BASE = 32'h0000_1000,
  parameter int WORDS = 256
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  fb_pkg::axil_addr_t  awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  fb_pkg::chunk_data_t wdata,
  input  fb_pkg::strobe_t     wstrb,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic                err_odd  // slverr on odd chunk addresses
);

  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

  fb_pkg::chunk_data_t mem [WORDS];
  fb_pkg::axil_addr_t addr_q;
  fb_pkg::chunk_data_t data_q;
  fb_pkg::strobe_t strb_q;
  fb_pkg::chunk_data_t merged;
  logic [IDX_W-1:0] idx;
  logic aw_got;
  logic w_got;
  logic [1:0] aw_wait;
  logic [1:0] w_wait;
  logic [1:0] b_wait;

  // preset pattern with one value per pixel address
  initial begin
    fb_pkg::chunk_data_t word;
    for (int w = 0; w < WORDS; w++) begin
      for (int l = 0; l < fb_pkg::PIX_PER_CHUNK; l++) begin
        word[16 * l +: 16] = 16'((w * 8 + l) * 40503) ^ 16'ha5c3;
      end
      mem[w] <= word;
    end
  end

  always_comb begin
    idx = IDX_W'((addr_q - BASE) >> 4);
    merged = mem[idx];
    for (int b = 0; b < fb_pkg::CHUNK_BYTES; b++) begin
      if (strb_q[b]) merged[8 * b +: 8] = data_q[8 * b +: 8];
    end
  end

  always @(posedge clk_in) begin
    if (rst_in) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      bresp <= 2'b00;
      aw_got <= 1'b0;
      w_got <= 1'b0;
      aw_wait <= 2'd0;
      w_wait <= 2'd0;
      b_wait <= 2'd0;
    end else begin
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_got <= 1'b1;
        addr_q <= awaddr;
        aw_wait <= 2'($urandom % 4);
      end else if (awvalid && !aw_got) begin
        if (aw_wait == 2'd0) awready <= 1'b1;
        else aw_wait <= aw_wait - 2'd1;
      end

      if (wvalid && wready) begin
        wready <= 1'b0;
        w_got <= 1'b1;
        data_q <= wdata;
        strb_q <= wstrb;
        w_wait <= 2'($urandom % 4);
      end else if (wvalid && !w_got) begin
        if (w_wait == 2'd0) wready <= 1'b1;
        else w_wait <= w_wait - 2'd1;
      end

      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_got <= 1'b0;
        w_got <= 1'b0;
        b_wait <= 2'($urandom % 4);
      end else if (aw_got && w_got && !bvalid) begin
        if (b_wait == 2'd0) begin
          bvalid <= 1'b1;
          bresp <= (err_odd && idx[0]) ? 2'b10 : 2'b00;
          mem[idx] <= merged;  // written even when answered with slverr
        end else begin
          b_wait <= b_wait - 2'd1;
        end
      end
    end
  end

endmodule

/* fb_pkg.sv */
package fb_pkg;

  // pixel and frame geometry
  localparam int PIX_PER_CHUNK = 8;
  localparam int CHUNK_BYTES = 16;

  typedef logic [15:0] pixel_t;       // rgb565
  typedef logic [21:0] pix_addr_t;    // row * hres + col, up to 2048x2048
  typedef logic [18:0] chunk_addr_t;  // pix_addr / 8
  typedef logic [15:0] strobe_t;      // one bit per byte of a chunk
  typedef logic [127:0] chunk_data_t;
  typedef logic [10:0] coord_t;
  typedef logic [31:0] axil_addr_t;

  // one horizontal span, len of zero is treated as one pixel
  typedef struct packed {
    coord_t row;
    coord_t col_start;
    coord_t len;
    pixel_t colour;
  } span_cmd_t;

  typedef struct packed {
    pix_addr_t addr;
    pixel_t colour;
    logic last;  // final pixel of its span
  } pix_wr_t;

  // eight pixels sharing one aligned group, lane n at bits 16n+15:16n
  typedef struct packed {
    chunk_addr_t addr;
    chunk_data_t data;
    strobe_t strb;
  } chunk_t;

endpackage

/* fb_write_tb.sv */
`timescale 1ns/1ps

module fb_write_tb;

  localparam int HRES = 64;
  localparam int VRES = 32;
  localparam int FIFO_DEPTH = 4;
  localparam fb_pkg::axil_addr_t FB_BASE = 32'h0000_1000;
  localparam int FRAME_PIX = HRES * VRES;
  localparam int N_DIRECTED = 12;
  localparam int N_RANDOM = 200;
  localparam int N_ERR = 20;
  localparam int LIMIT = 200 * (N_DIRECTED + N_RANDOM + N_ERR) + 1000;

  logic clk_in;
  logic rst_in;
  fb_pkg::span_cmd_t span_cmd;
  logic span_valid;
  logic span_ready;
  fb_pkg::axil_addr_t awaddr;
  logic awvalid;
  logic awready;
  fb_pkg::chunk_data_t wdata;
  fb_pkg::strobe_t wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [15:0] err_count;
  logic err_mode;

  fb_pkg::pixel_t shadow [FRAME_PIX];
  fb_pkg::axil_addr_t exp_addr_q [$];
  int exp_chunks;
  int exp_errs;
  int b_total;

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  fb_write_top #(
    .HRES(HRES),
    .VRES(VRES),
    .FIFO_DEPTH(FIFO_DEPTH),
    .FB_BASE(FB_BASE)
  ) dut0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .span_cmd(span_cmd), .span_valid(span_valid), .span_ready(span_ready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready), .err_count(err_count)
  );

  fb_axil_mem_model #(
    .BASE(FB_BASE),
    .WORDS(FRAME_PIX / fb_pkg::PIX_PER_CHUNK)
  ) mem0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready), .err_odd(err_mode)
  );

  always @(posedge clk_in) begin
    if (rst_in) b_total <= 0;
    else if (bvalid && bready) b_total <= b_total + 1;
  end

  // writes leave in span order, one per touched chunk
  always @(posedge clk_in) begin
    if (!rst_in && awvalid && awready) begin
      if (exp_addr_q.size() == 0) report_error("write issued with no chunk expected");
      else check_addr(awaddr, exp_addr_q.pop_front());
    end
  end

  initial begin
    repeat (LIMIT) @(posedge clk_in);
    $display("timeout: memory writes did not complete within %0d cycles", LIMIT);
    $display("Checks failed");
    $fatal(1);
  end

  function automatic fb_pkg::pixel_t fill_value(input int p);
    return 16'(p * 40503) ^ 16'ha5c3;
  endfunction

  // updates the shadow frame and the expected write addresses
  function automatic int ref_span(input fb_pkg::span_cmd_t cmd, input logic err_on,
                                  output int errs);
    int row;
    int col;
    int len;
    int first;
    int last;
    row = int'(cmd.row);
    col = int'(cmd.col_start);
    len = (cmd.len == '0) ? 1 : int'(cmd.len);
    errs = 0;
    if (row >= VRES || col >= HRES) return 0;  // dropped
    if (col + len > HRES) len = HRES - col;
    first = row * HRES + col;
    last = first + len - 1;
    for (int a = first; a <= last; a++) shadow[a] = cmd.colour;
    for (int c = first / 8; c <= last / 8; c++) begin
      exp_addr_q.push_back(FB_BASE + fb_pkg::axil_addr_t'(c * 16));  // 16 bytes per chunk
      if (err_on && (c % 2 == 1)) errs++;
    end
    return last / 8 - first / 8 + 1;
  endfunction

  function automatic fb_pkg::span_cmd_t make_span(input int row, input int col, input int len,
                                                  input int colour);
    fb_pkg::span_cmd_t cmd;
    cmd.row = fb_pkg::coord_t'(row);
    cmd.col_start = fb_pkg::coord_t'(col);
    cmd.len = fb_pkg::coord_t'(len);
    cmd.colour = fb_pkg::pixel_t'(colour);
    return cmd;
  endfunction

  function automatic fb_pkg::span_cmd_t random_span();
    return make_span($urandom % (VRES + 4), $urandom % (HRES + 6), $urandom % 40, $urandom);
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_pixel(input fb_pkg::pixel_t got, input fb_pkg::pixel_t exp, input int p);
    if (got !== exp) begin
      report_error($sformatf("pixel row %0d col %0d is %h, expected %h",
                             p / HRES, p % HRES, got, exp));
    end
  endtask

  task automatic check_count(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) report_error($sformatf("%s count is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_addr(input fb_pkg::axil_addr_t got, input fb_pkg::axil_addr_t exp);
    if (got !== exp) report_error($sformatf("write address is %h, expected %h", got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) report_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // called at 1 ns after an edge
  task automatic send_span(input fb_pkg::span_cmd_t cmd);
    int errs;
    int n;
    n = ref_span(cmd, err_mode, errs);
    exp_chunks += n;
    exp_errs += errs;
    span_cmd = cmd;
    span_valid = 1'b1;
    while (span_ready !== 1'b1) begin
      @(posedge clk_in);
      #1;
    end
    @(posedge clk_in);  // handshake edge
    #1;
    span_valid = 1'b0;
  endtask

  task automatic check_frame();
    fb_pkg::chunk_data_t word;
    for (int p = 0; p < FRAME_PIX; p++) begin
      word = mem0.mem[p / fb_pkg::PIX_PER_CHUNK];
      check_pixel(word[(p % 8) * 16 +: 16], shadow[p], p);
    end
  endtask

  task automatic wait_writes();
    while (b_total < exp_chunks) begin
      @(posedge clk_in);
      #1;
    end
    check_count(16'(b_total), 16'(exp_chunks), "write response");
    check_count(err_count, 16'(exp_errs), "error response");
    check_frame();
  endtask

  initial begin
    void'($urandom(72934));
    rst_in = 1'b1;
    span_valid = 1'b0;
    span_cmd = '0;
    err_mode = 1'b0;
    exp_chunks = 0;
    exp_errs = 0;
    for (int p = 0; p < FRAME_PIX; p++) shadow[p] = fill_value(p);
    repeat (4) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    check_flag(awvalid, 1'b0, "awvalid after reset");
    check_flag(wvalid, 1'b0, "wvalid after reset");
    check_flag(bready, 1'b0, "bready after reset");
    check_flag(span_ready, 1'b0, "span_ready at reset release");
    @(posedge clk_in);
    #1;
    check_flag(span_ready, 1'b1, "span_ready after first edge");

    send_span(make_span(2, 13, 1, 16'hf800));  // single pixel
    wait_writes();
    send_span(make_span(3, 16, 8, 16'h07e0));  // one aligned chunk
    wait_writes();

    send_span(make_span(5, 5, 20, 16'h001f));
    send_span(make_span(6, 30, 17, 16'h1234));
    send_span(make_span(7, 1, 45, 16'hbeef));
    wait_writes();

    send_span(make_span(8, 60, 10, 16'h4321));  // clipped at the row end
    send_span(make_span(9, 40, 500, 16'h0f0f));
    send_span(make_span(10, 3, 0, 16'h7777));
    send_span(make_span(32, 0, 5, 16'hdead));  // row out of range
    send_span(make_span(1, 64, 3, 16'hdead));
    send_span(make_span(2047, 10, 4, 16'hdead));
    send_span(make_span(11, 63, 2, 16'h5555));
    wait_writes();

    repeat (N_RANDOM) send_span(random_span());
    wait_writes();

    err_mode = 1'b1;
    repeat (N_ERR) send_span(random_span());
    wait_writes();
    err_mode = 1'b0;

    $display("All checks passed");
    $finish;
  end

endmodule

/* fb_write_top.sv */
`timescale 1ns/1ps

module fb_write_top #(
  parameter int                 HRES = 640,
  parameter int                 VRES = 480,
  parameter int                 FIFO_DEPTH = 4,
  parameter fb_pkg::axil_addr_t FB_BASE = 32'h0000_0000
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  fb_pkg::span_cmd_t   span_cmd,
  input  logic                span_valid,
  output logic                span_ready,
  output fb_pkg::axil_addr_t  awaddr,
  output logic                awvalid,
  input  logic                awready,
  output fb_pkg::chunk_data_t wdata,
  output fb_pkg::strobe_t     wstrb,
  output logic                wvalid,
  input  logic                wready,
  input  logic [1:0]          bresp,
  input  logic                bvalid,
  output logic                bready,
  output logic [15:0]         err_count
);

  fb_pkg::pix_wr_t pix;
  logic pix_valid;
  logic pix_ready;

  fb_pkg::chunk_t st_chunk;  // stacker to fifo
  logic st_valid;
  logic st_ready;

  fb_pkg::chunk_t wr_chunk;  // fifo to writer
  logic wr_valid;
  logic wr_ready;

  span_rasterizer #(
    .HRES(HRES),
    .VRES(VRES)
  ) rast0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .span_cmd(span_cmd),
    .span_valid(span_valid),
    .span_ready(span_ready),
    .pix(pix),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready)
  );

  pixel_stacker #(
    .HRES(HRES),
    .VRES(VRES)
  ) stack0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .pix(pix),
    .pix_valid(pix_valid),
    .pix_ready(pix_ready),
    .chunk(st_chunk),
    .chunk_valid(st_valid),
    .chunk_ready(st_ready)
  );

  chunk_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .in_chunk(st_chunk),
    .in_valid(st_valid),
    .in_ready(st_ready),
    .out_chunk(wr_chunk),
    .out_valid(wr_valid),
    .out_ready(wr_ready)
  );

  axil_chunk_writer #(
    .FB_BASE(FB_BASE)
  ) writer0 (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .chunk(wr_chunk),
    .chunk_valid(wr_valid),
    .chunk_ready(wr_ready),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .err_count(err_count)
  );

endmodule

/* flist.f */
fb_pkg.sv
span_rasterizer.sv
pixel_stacker.sv
chunk_fifo.sv
axil_chunk_writer.sv
fb_write_top.sv
fb_axil_mem_model.sv
fb_write_tb.sv

/* pixel_stacker.sv */
`timescale 1ns/1ps

module pixel_stacker #(
  parameter int HRES = 640,
  parameter int VRES = 480
) (
  input  logic            clk_in,
  input  logic            rst_in,
  input  fb_pkg::pix_wr_t pix,
  input  logic            pix_valid,
  output logic            pix_ready,
  output fb_pkg::chunk_t  chunk,
  output logic            chunk_valid,
  input  logic            chunk_ready
);

  localparam int LANE_W = $clog2(fb_pkg::PIX_PER_CHUNK);
  localparam int PIX_W = $bits(fb_pkg::pixel_t);
  localparam int FRAME_CHUNKS = (HRES * VRES) / fb_pkg::PIX_PER_CHUNK;
  localparam int CA_W = (FRAME_CHUNKS > 1) ? $clog2(FRAME_CHUNKS) : 1;

  // open chunk being filled
  fb_pkg::chunk_data_t open_data;
  fb_pkg::strobe_t open_strb;
  logic [CA_W-1:0] open_addr;
  logic flush_pending;  // span ended, chunk waits for the output register

  logic [CA_W-1:0] pix_chunk;
  logic [LANE_W-1:0] lane;
  fb_pkg::strobe_t lane_strb;
  logic out_free;
  logic addr_diff;
  logic flush;
  logic accept;

  always_comb begin
    pix_chunk = pix.addr[LANE_W +: CA_W];
    lane = pix.addr[LANE_W-1:0];
    lane_strb = fb_pkg::strobe_t'(2'b11) << (lane * 2);  // two bytes per pixel
    out_free = !chunk_valid || chunk_ready;
    addr_diff = (open_strb != '0) && (pix_chunk != open_addr);
    flush = out_free && (flush_pending || (pix_valid && addr_diff));
    pix_ready = out_free || !(flush_pending || addr_diff);
    accept = pix_valid && pix_ready;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      chunk_valid <= 1'b0;
      open_strb <= '0;
      flush_pending <= 1'b0;
    end else begin
      if (flush) begin
        chunk_valid <= 1'b1;  // never empty, strobe is set by now
        open_strb <= '0;
        flush_pending <= 1'b0;
      end else if (chunk_ready) begin
        chunk_valid <= 1'b0;
      end

      if (accept) begin
        open_strb <= (flush ? '0 : open_strb) | lane_strb;
        flush_pending <= pix.last;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      open_data[lane * PIX_W +: PIX_W] <= pix.colour;
      open_addr <= pix_chunk;
    end
    if (flush) begin
      chunk.addr <= fb_pkg::chunk_addr_t'(open_addr);
      chunk.data <= open_data;
      chunk.strb <= open_strb;
    end
  end

endmodule

/* span_rasterizer.sv */
`timescale 1ns/1ps

module span_rasterizer #(
  parameter int HRES = 640,
  parameter int VRES = 480
) (
  input  logic              clk_in,
  input  logic              rst_in,
  input  fb_pkg::span_cmd_t span_cmd,
  input  logic              span_valid,
  output logic              span_ready,
  output fb_pkg::pix_wr_t   pix,
  output logic              pix_valid,
  input  logic              pix_ready
);

  typedef enum logic {
    ST_IDLE,
    ST_EMIT
  } state_t;

  localparam logic [11:0] HRES_W = 12'(HRES);
  localparam logic [11:0] VRES_W = 12'(VRES);

  state_t state;
  logic [11:0] remaining;  // pixels left, current one included
  logic [11:0] avail;
  logic [11:0] req_len;
  logic [11:0] clip_len;
  logic in_range;
  fb_pkg::pix_addr_t row_base;
  logic take_cmd;

  always_comb begin
    avail = HRES_W - {1'b0, span_cmd.col_start};
    req_len = (span_cmd.len == '0) ? 12'd1 : {1'b0, span_cmd.len};
    clip_len = (req_len > avail) ? avail : req_len;  // stop at row end
    in_range = ({1'b0, span_cmd.row} < VRES_W) && ({1'b0, span_cmd.col_start} < HRES_W);
    row_base = fb_pkg::pix_addr_t'(span_cmd.row) * fb_pkg::pix_addr_t'(HRES);
    take_cmd = span_valid && span_ready && in_range;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ST_IDLE;
      span_ready <= 1'b0;
      pix_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          span_ready <= 1'b1;  // out of range commands are taken and dropped
          if (take_cmd) begin
            state <= ST_EMIT;
            span_ready <= 1'b0;
            pix_valid <= 1'b1;
          end
        end
        ST_EMIT: begin
          if (pix_ready && pix.last) begin
            state <= ST_IDLE;
            pix_valid <= 1'b0;
            span_ready <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // pixel payload, loaded while idle and stepped per accepted pixel
  always_ff @(posedge clk_in) begin
    if (state == ST_IDLE) begin
      pix.addr <= row_base + fb_pkg::pix_addr_t'(span_cmd.col_start);
      pix.colour <= span_cmd.colour;
      pix.last <= (clip_len == 12'd1);
      remaining <= clip_len;
    end else if (pix_ready) begin
      pix.addr <= pix.addr + fb_pkg::pix_addr_t'(1);
      pix.last <= (remaining == 12'd2);
      remaining <= remaining - 12'd1;
    end
  end

endmodule
